// ==== discrete_i2c.f ====
hdl/i2c_bus_pkg.sv
hdl/i2c_frame_pkg.sv
hdl/i2c_stage_if.sv
hdl/tx_char_fifo.sv
hdl/i2c_tx_sequencer.sv
hdl/i2c_pad_driver.sv
hdl/i2c_rx_decoder.sv
hdl/i2c_addr_match.sv
hdl/discrete_i2c_top.sv
verification/i2c_bus_checker.sv
verification/tb_discrete_i2c.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module tb_discrete_i2c \
		-f discrete_i2c.f -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== verification/tb_discrete_i2c.sv ====
`default_nettype none

module tb_discrete_i2c;
	localparam int half_bit = 12;
	localparam int total_frames = 17;
	// A four byte frame from the slow master plus the idle gap stays below this
	localparam int frame_clocks = 1200;
	localparam int timeout_limit = total_frames * frame_clocks + 2000;

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic [7:0] tx_char;
	logic tx_char_latch;
	logic tx_req;
	logic [7:0] addr_match_char;
	logic addr_match_latch;
	logic addr_match_reset;
	logic master_scl_low;
	logic master_sda_low;
	logic scl_line;
	logic sda_line;
	logic scl_pd;
	logic scl_pu_n;
	logic scl_tri;
	logic sda_pd;
	logic sda_pu_n;
	logic sda_tri;
	logic [7:0] rx_char;
	logic rx_char_latch;
	logic rx_req;

	integer seed = 86802;
	int cycle_count = 0;
	int frames_sent = 0;
	logic [7:0] model_table [16];
	logic [7:0] master_bytes [$];

	always #20 clk = ~clk;

	// Open-drain bus with pull-up resistors
	assign scl_line = !(scl_pd || master_scl_low);
	assign sda_line = !(sda_pd || master_sda_low);

	discrete_i2c_top #(
		.phase_cycles(7)
	) uut (
		.clk(clk),
		.reset(reset),
		.tx_char(tx_char),
		.tx_char_latch(tx_char_latch),
		.tx_req(tx_req),
		.addr_match_char(addr_match_char),
		.addr_match_latch(addr_match_latch),
		.addr_match_reset(addr_match_reset),
		.scl_in(scl_line),
		.sda_in(sda_line),
		.scl_pd(scl_pd),
		.scl_pu_n(scl_pu_n),
		.scl_tri(scl_tri),
		.sda_pd(sda_pd),
		.sda_pu_n(sda_pu_n),
		.sda_tri(sda_tri),
		.rx_char(rx_char),
		.rx_char_latch(rx_char_latch),
		.rx_req(rx_req)
	);

	i2c_bus_checker bus_check (
		.clk(clk),
		.reset(reset),
		.scl(scl_line),
		.sda(sda_line),
		.scl_pd(scl_pd),
		.scl_pu_n(scl_pu_n),
		.scl_tri(scl_tri),
		.sda_pd(sda_pd),
		.sda_pu_n(sda_pu_n),
		.sda_tri(sda_tri),
		.rx_char(rx_char),
		.rx_char_latch(rx_char_latch),
		.rx_req(rx_req)
	);

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= timeout_limit) begin
			$display("Timeout after %0d cycles with frames still outstanding", cycle_count);
			$display("TEST FAILED");
			$finish;
		end
	end

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge clk);
	endtask

	task wait_frames(input int n);
		frames_sent += n;
		wait (bus_check.frames_closed >= frames_sent);
		wait_cycles(40);
	endtask

	task queue_tx_frame(input int len, input string name);
		logic [7:0] b;
		for (int i = 0; i < len; i++) begin
			b = 8'($random(seed));
			@(negedge clk);
			tx_char = b;
			tx_char_latch = 1'b1;
			bus_check.push_byte(b);
			@(negedge clk);
			tx_char_latch = 1'b0;
		end
		bus_check.push_frame(len, 1'b0, name);
		@(negedge clk);
		tx_req = 1'b1;
		@(negedge clk);
		tx_req = 1'b0;
	endtask

	task pick_master_bytes(input string name);
		int len;
		logic [7:0] first;
		len = 1 + ({$random(seed)} % 4);
		master_bytes.delete();
		for (int i = 0; i < len; i++)
			master_bytes.push_back(8'($random(seed)));
		foreach (master_bytes[i])
			bus_check.push_byte(master_bytes[i]);
		first = master_bytes[0];
		bus_check.push_frame(len, model_table[first[7:4]][first[3:1]], name);
	endtask

	task drive_master_frame();
		@(negedge clk);
		master_sda_low = 1'b1;
		wait_cycles(half_bit);
		master_scl_low = 1'b1;
		wait_cycles(half_bit);
		foreach (master_bytes[i]) begin
			// Eight data bits, then SDA is let go for the ack slot
			for (int k = 8; k >= 0; k--) begin
				master_sda_low = (k == 0) ? 1'b0 : !master_bytes[i][k-1];
				wait_cycles(half_bit);
				master_scl_low = 1'b0;
				wait_cycles(half_bit);
				master_scl_low = 1'b1;
				wait_cycles(2);
			end
		end
		master_sda_low = 1'b1;
		wait_cycles(half_bit);
		master_scl_low = 1'b0;
		wait_cycles(half_bit);
		master_sda_low = 1'b0;
		wait_cycles(half_bit);
	endtask

	initial begin
		tx_char = '0;
		tx_char_latch = 1'b0;
		tx_req = 1'b0;
		addr_match_char = '0;
		addr_match_latch = 1'b0;
		addr_match_reset = 1'b0;
		master_scl_low = 1'b0;
		master_sda_low = 1'b0;
		for (int i = 0; i < 16; i++)
			model_table[i] = '0;
		wait_cycles(5);
		reset = 1'b0;
		wait_cycles(50);

		for (int i = 0; i < 4; i++) begin
			queue_tx_frame(1 + ({$random(seed)} % 4), "tx frame");
			wait_frames(1);
		end
		for (int i = 0; i < 2; i++) begin
			queue_tx_frame(0, "empty frame");
			wait_frames(1);
		end
		for (int i = 0; i < 3; i++) begin
			pick_master_bytes("rx frame");
			drive_master_frame();
			wait_frames(1);
		end

		// The request lands while the master owns the bus
		pick_master_bytes("busy master frame");
		fork
			drive_master_frame();
			begin
				wait_cycles(half_bit * 4);
				queue_tx_frame(2, "deferred tx frame");
			end
		join
		wait_frames(2);

		@(negedge clk);
		addr_match_reset = 1'b1;
		@(negedge clk);
		addr_match_reset = 1'b0;
		for (int i = 0; i < 16; i++) begin
			model_table[i] = 8'($random(seed));
			addr_match_char = model_table[i];
			addr_match_latch = 1'b1;
			@(negedge clk);
			addr_match_latch = 1'b0;
		end
		for (int i = 0; i < 6; i++) begin
			pick_master_bytes("address match frame");
			drive_master_frame();
			wait_frames(1);
		end

		$display("tests %0d, errors %0d", bus_check.test_count, bus_check.error_count);
		if (bus_check.error_count == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verification/i2c_bus_checker.sv ====
`default_nettype none

module i2c_bus_checker (
	input logic clk,
	input logic reset,
	input logic scl,
	input logic sda,
	input logic scl_pd,
	input logic scl_pu_n,
	input logic scl_tri,
	input logic sda_pd,
	input logic sda_pu_n,
	input logic sda_tri,
	input logic [7:0] rx_char,
	input logic rx_char_latch,
	input logic rx_req
);
	int error_count = 0;
	int test_count = 0;
	int frames_closed = 0;
	int post_reset = 0;
	int bit_count = 0;
	bit reset_seen = 0;
	bit in_frame = 0;
	bit frame_stopped = 0;
	logic scl_q = 1'b1;
	logic sda_q = 1'b1;
	logic [7:0] shreg;

	// Expected frames, with their bytes flattened into one queue
	int exp_len [$];
	bit exp_ack_low [$];
	string exp_name [$];
	logic [7:0] exp_bytes [$];

	// What the bus and the receiver actually produced in the current frame
	logic [7:0] bus_bytes [$];
	logic bus_acks [$];
	logic [7:0] rx_bytes [$];

	task push_byte(input logic [7:0] b);
		exp_bytes.push_back(b);
	endtask

	task push_frame(input int len, input bit ack_low, input string name);
		exp_len.push_back(len);
		exp_ack_low.push_back(ack_low);
		exp_name.push_back(name);
	endtask

	function automatic int compare_value(input string name, input logic [7:0] got,
			input logic [7:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %s: got %h, expected %h", name, got, exp);
			return 1;
		end
		return 0;
	endfunction

	function automatic int idle_outputs_errors();
		int errs;
		errs = compare_value("scl_pd", scl_pd, 1'b0);
		errs += compare_value("scl_pu_n", scl_pu_n, 1'b1);
		errs += compare_value("scl_tri", scl_tri, 1'b1);
		errs += compare_value("sda_pd", sda_pd, 1'b0);
		errs += compare_value("sda_pu_n", sda_pu_n, 1'b1);
		errs += compare_value("sda_tri", sda_tri, 1'b1);
		errs += compare_value("rx_char_latch", rx_char_latch, 1'b0);
		errs += compare_value("rx_req", rx_req, 1'b0);
		return errs;
	endfunction

	task close_frame();
		int errs;
		int len;
		int exp_pulses;
		bit ack_low;
		string name;
		logic [7:0] b;
		errs = 0;
		if (exp_len.size() == 0) begin
			$display("rx_req pulsed with no frame expected");
			error_count++;
			return;
		end
		len = exp_len.pop_front();
		ack_low = exp_ack_low.pop_front();
		name = exp_name.pop_front();
		if (!frame_stopped) begin
			$display("rx_req pulsed without a stop on the bus");
			errs++;
		end
		// Nine SCL pulses per byte, plus the one that leads into the stop
		exp_pulses = (len > 0) ? 9 * len + 1 : 0;
		if (bit_count != exp_pulses) begin
			$display("Bus frame had %0d SCL pulses, %0d expected", bit_count, exp_pulses);
			errs++;
		end
		errs += compare_value("bus_byte_count", 8'(bus_bytes.size()), 8'(len));
		errs += compare_value("rx_char_count", 8'(rx_bytes.size()), 8'(len));
		for (int i = 0; i < len; i++) begin
			b = exp_bytes.pop_front();
			if (i < bus_bytes.size())
				errs += compare_value("bus_byte", bus_bytes[i], b);
			if (i < rx_bytes.size())
				errs += compare_value("rx_char", rx_bytes[i], b);
			if (i < bus_acks.size())
				errs += compare_value("sda_ack", bus_acks[i], !ack_low);
		end
		test_count++;
		error_count += errs;
		frames_closed++;
		$display("test %0d %s: %s", test_count, name, (errs == 0) ? "ok" : "mismatch");
		frame_stopped = 0;
		rx_bytes.delete();
	endtask

	always @(posedge clk) begin
		if (reset) begin
			// The first edge only loads the reset values
			if (reset_seen)
				error_count += idle_outputs_errors();
			reset_seen = 1;
			post_reset = 40;
			in_frame = 0;
		end else begin
			if (post_reset > 0) begin
				error_count += idle_outputs_errors();
				post_reset--;
				if (post_reset == 0) begin
					test_count++;
					$display("test %0d reset state: done", test_count);
				end
			end

			if (scl && scl_q && sda_q && !sda) begin
				if (in_frame) begin
					$display("Start condition inside a frame on the bus");
					error_count++;
				end
				in_frame = 1;
				bit_count = 0;
				bus_bytes.delete();
				bus_acks.delete();
			end else if (scl && scl_q && !sda_q && sda) begin
				if (!in_frame) begin
					$display("Stop condition without a start on the bus");
					error_count++;
				end
				in_frame = 0;
				frame_stopped = 1;
			end else if (scl && !scl_q && in_frame) begin
				// Every ninth bit is the ack slot
				if (bit_count % 9 < 8) begin
					shreg = {shreg[6:0], sda};
				end else begin
					bus_bytes.push_back(shreg);
					bus_acks.push_back(sda);
				end
				bit_count++;
			end

			if (rx_char_latch)
				rx_bytes.push_back(rx_char);
			if (rx_req)
				close_frame();
		end
		scl_q = scl;
		sda_q = sda;
	end

endmodule

`default_nettype wire

// ==== hdl/discrete_i2c_top.sv ====
`default_nettype none

module discrete_i2c_top #(
	parameter int phase_cycles = i2c_bus_pkg::default_phase_cycles,
	parameter int release_cycles = i2c_bus_pkg::default_release_cycles
) (
	input logic clk,
	input logic reset,
	input logic [7:0] tx_char,
	input logic tx_char_latch,
	input logic tx_req,
	input logic [7:0] addr_match_char,
	input logic addr_match_latch,
	input logic addr_match_reset,
	input logic scl_in,
	input logic sda_in,
	output logic scl_pd,
	output logic scl_pu_n,
	output logic scl_tri,
	output logic sda_pd,
	output logic sda_pu_n,
	output logic sda_tri,
	output logic [7:0] rx_char,
	output logic rx_char_latch,
	output logic rx_req
);
	tx_queue_if q_if ();
	pad_ctrl_if pad_if ();

	i2c_frame_pkg::queue_entry_t push_entry;
	i2c_frame_pkg::rx_byte_u rx_byte;
	logic push;
	logic rx_busy;
	logic addr_capture;
	logic addr_hit;
	logic ack;

	// A frame request takes the queue slot as a boundary mark
	assign push_entry = '{frame_end: tx_req, data: tx_char};
	assign push = tx_req || tx_char_latch;
	assign rx_char = rx_byte.data;

	tx_char_fifo fifo (
		.clk(clk),
		.reset(reset),
		.push_entry(push_entry),
		.push(push),
		.q(q_if.producer)
	);

	i2c_tx_sequencer #(
		.phase_cycles(phase_cycles)
	) sequencer (
		.clk(clk),
		.reset(reset),
		.frame_req(tx_req),
		.rx_busy(rx_busy),
		.q(q_if.consumer),
		.pad(pad_if.sequencer)
	);

	i2c_pad_driver #(
		.phase_cycles(phase_cycles),
		.release_cycles(release_cycles)
	) pads (
		.clk(clk),
		.reset(reset),
		.ack(ack),
		.pad(pad_if.pad),
		.scl_pd(scl_pd),
		.scl_pu_n(scl_pu_n),
		.scl_tri(scl_tri),
		.sda_pd(sda_pd),
		.sda_pu_n(sda_pu_n),
		.sda_tri(sda_tri)
	);

	i2c_rx_decoder decoder (
		.clk(clk),
		.reset(reset),
		.scl_in(scl_in),
		.sda_in(sda_in),
		.addr_hit(addr_hit),
		.rx_byte(rx_byte),
		.rx_char_latch(rx_char_latch),
		.rx_req(rx_req),
		.rx_busy(rx_busy),
		.addr_capture(addr_capture),
		.ack(ack)
	);

	i2c_addr_match matcher (
		.clk(clk),
		.reset(reset),
		.wr_char(addr_match_char),
		.wr_latch(addr_match_latch),
		.wr_rewind(addr_match_reset),
		.addr_capture(addr_capture),
		.rx_byte(rx_byte),
		.addr_hit(addr_hit)
	);

endmodule

`default_nettype wire

// ==== hdl/i2c_addr_match.sv ====
`default_nettype none

module i2c_addr_match (
	input logic clk,
	input logic reset,
	input logic [7:0] wr_char,
	input logic wr_latch,
	input logic wr_rewind,
	input logic addr_capture,
	input i2c_frame_pkg::rx_byte_u rx_byte,
	output logic addr_hit
);
	localparam int ptr_bits = $clog2(i2c_frame_pkg::addr_table_words);

	logic [7:0] addr_table [i2c_frame_pkg::addr_table_words];
	logic [ptr_bits-1:0] wr_ptr;
	i2c_frame_pkg::rx_byte_u captured;

	// The last value seen while capture is open is the complete first byte
	always_ff @(posedge clk) begin
		if (addr_capture)
			captured <= rx_byte;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			for (int i = 0; i < i2c_frame_pkg::addr_table_words; i++)
				addr_table[i] <= '0;
		end else begin
			if (wr_latch)
				addr_table[wr_ptr] <= wr_char;
			if (wr_rewind)
				wr_ptr <= '0;
			else if (wr_latch)
				wr_ptr <= wr_ptr + 1'b1;
		end
	end

	// Upper nibble picks the word, the next three bits pick the bit
	assign addr_hit = addr_table[captured.addr.word][captured.addr.bit_idx];

endmodule

`default_nettype wire

// ==== hdl/i2c_rx_decoder.sv ====
`default_nettype none

module i2c_rx_decoder (
	input logic clk,
	input logic reset,
	input logic scl_in,
	input logic sda_in,
	input logic addr_hit,
	output i2c_frame_pkg::rx_byte_u rx_byte,
	output logic rx_char_latch,
	output logic rx_req,
	output logic rx_busy,
	output logic addr_capture,
	output logic ack
);
	localparam logic [1:0] rx_idle = 2'd0;
	localparam logic [1:0] rx_data = 2'd1;
	localparam logic [1:0] rx_ack = 2'd2;

	logic [1:0] state;
	logic [1:0] next_state;
	logic scl_meta, scl_sync, scl_last;
	logic sda_meta, sda_sync, sda_last;
	logic scl_rise;
	logic scl_fall;
	logic stop_seen;
	logic [2:0] bit_count;
	logic count_step, count_clear;
	logic shift_in, byte_done, stop_done;
	logic capture_set, capture_clear;
	logic ack_set, ack_clear;

	assign scl_rise = scl_sync && !scl_last;
	assign scl_fall = !scl_sync && scl_last;
	assign stop_seen = sda_sync && !sda_last && scl_sync;

	always_comb begin
		next_state = state;
		count_step = 1'b0;
		count_clear = 1'b0;
		shift_in = 1'b0;
		byte_done = 1'b0;
		stop_done = 1'b0;
		capture_set = 1'b0;
		capture_clear = 1'b0;
		ack_set = 1'b0;
		ack_clear = 1'b0;

		case (state)
			rx_idle: begin
				count_clear = 1'b1;
				capture_set = 1'b1;
				if (!sda_sync && scl_sync)
					next_state = rx_data;
			end

			rx_data: begin
				if (scl_rise) begin
					shift_in = 1'b1;
					if (bit_count == 3'd7) begin
						count_clear = 1'b1;
						byte_done = 1'b1;
						next_state = rx_ack;
					end else begin
						count_step = 1'b1;
					end
				end
			end

			rx_ack: begin
				// Only the first byte of a frame is an address
				capture_clear = 1'b1;
				if (scl_fall) begin
					if (bit_count == 3'd1) begin
						ack_clear = 1'b1;
						count_clear = 1'b1;
						next_state = rx_data;
					end else begin
						count_step = 1'b1;
						ack_set = addr_hit;
					end
				end
			end

			default: next_state = rx_idle;
		endcase

		if (state != rx_idle && stop_seen) begin
			stop_done = 1'b1;
			ack_clear = 1'b1;
			next_state = rx_idle;
		end
	end

	always_ff @(posedge clk) begin
		if (shift_in)
			rx_byte.data <= {rx_byte.data[6:0], sda_sync};
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			// An idle bus reads high on both lines
			scl_meta <= 1'b1;
			scl_sync <= 1'b1;
			scl_last <= 1'b1;
			sda_meta <= 1'b1;
			sda_sync <= 1'b1;
			sda_last <= 1'b1;
			state <= rx_idle;
			bit_count <= '0;
			rx_char_latch <= 1'b0;
			rx_req <= 1'b0;
			rx_busy <= 1'b0;
			addr_capture <= 1'b0;
			ack <= 1'b0;
		end else begin
			scl_meta <= scl_in;
			scl_sync <= scl_meta;
			scl_last <= scl_sync;
			sda_meta <= sda_in;
			sda_sync <= sda_meta;
			sda_last <= sda_sync;

			state <= next_state;
			rx_char_latch <= byte_done;
			rx_req <= stop_done;
			rx_busy <= (state != rx_idle);

			if (count_clear)
				bit_count <= '0;
			else if (count_step)
				bit_count <= bit_count + 3'd1;

			if (capture_set)
				addr_capture <= 1'b1;
			else if (capture_clear)
				addr_capture <= 1'b0;

			if (ack_clear)
				ack <= 1'b0;
			else if (ack_set)
				ack <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/i2c_pad_driver.sv ====
`default_nettype none

module i2c_pad_driver #(
	parameter int phase_cycles = i2c_bus_pkg::default_phase_cycles,
	parameter int release_cycles = i2c_bus_pkg::default_release_cycles
) (
	input logic clk,
	input logic reset,
	input logic ack,
	pad_ctrl_if.pad pad,
	output logic scl_pd,
	output logic scl_pu_n,
	output logic scl_tri,
	output logic sda_pd,
	output logic sda_pu_n,
	output logic sda_tri
);
	localparam logic [7:0] quarter = 8'(phase_cycles / 4);
	localparam logic [7:0] release_last = 8'(release_cycles);
	localparam i2c_bus_pkg::pad_ctrl_t released = '{pd: 1'b0, pu: 1'b0, hiz: 1'b1};
	localparam i2c_bus_pkg::pad_ctrl_t pull_up = '{pd: 1'b0, pu: 1'b1, hiz: 1'b0};

	i2c_bus_pkg::pad_ctrl_t scl_q;
	i2c_bus_pkg::pad_ctrl_t sda_q;
	logic [7:0] release_count;
	logic sda_step;

	// SDA only moves once SCL has had a quarter phase to settle
	assign sda_step = (pad.phase_count >= quarter);

	always_ff @(posedge clk) begin
		if (reset) begin
			scl_q <= released;
			sda_q <= released;
			release_count <= release_last;
		end else begin
			scl_q.pd <= pad.scl_drive && !pad.scl_value;
			scl_q.pu <= pad.scl_drive && pad.scl_value;
			scl_q.hiz <= !pad.scl_drive;

			if (sda_step) begin
				if (pad.sda_drive) begin
					sda_q.pd <= !pad.sda_value;
					sda_q.pu <= pad.sda_value;
					sda_q.hiz <= 1'b0;
					release_count <= '0;
				end else if (release_count < release_last) begin
					// Speed up the rising edge before handing the line to the pull-up resistor
					sda_q <= pull_up;
					release_count <= release_count + 8'd1;
				end else begin
					sda_q <= released;
				end
			end
		end
	end

	assign scl_pd = scl_q.pd;
	assign scl_pu_n = !scl_q.pu;
	assign scl_tri = scl_q.hiz;

	// The receiver's ack wins over whatever the sequencer asked for
	assign sda_pd = ack ? 1'b1 : sda_q.pd;
	assign sda_pu_n = ack ? 1'b1 : !sda_q.pu;
	assign sda_tri = ack ? 1'b0 : sda_q.hiz;

endmodule

`default_nettype wire

// ==== hdl/i2c_tx_sequencer.sv ====
`default_nettype none

module i2c_tx_sequencer #(
	parameter int phase_cycles = i2c_bus_pkg::default_phase_cycles
) (
	input logic clk,
	input logic reset,
	input logic frame_req,
	input logic rx_busy,
	tx_queue_if.consumer q,
	pad_ctrl_if.sequencer pad
);
	localparam logic [7:0] phase_last = 8'(phase_cycles);
	localparam logic [7:0] start_last = 8'(2 * phase_cycles);

	i2c_bus_pkg::bus_phase_t phase;
	i2c_bus_pkg::bus_phase_t next_phase;
	logic [7:0] count;
	logic [2:0] bit_idx;
	logic pending;
	logic bit_reload;
	logic bit_step;
	logic phase_done;
	logic head_is_mark;
	logic frame_begin;

	assign phase_done = (count == phase_last);
	assign frame_begin = (phase == i2c_bus_pkg::idle) && (next_phase == i2c_bus_pkg::start);

	// An empty queue is treated like a frame mark so nothing undefined goes out
	assign head_is_mark = !q.valid || q.entry.frame_end;

	assign pad.phase_count = count;

	always_comb begin
		next_phase = phase;
		bit_reload = 1'b0;
		bit_step = 1'b0;
		q.pop = 1'b0;
		pad.sda_drive = 1'b0;
		pad.sda_value = 1'b1;
		pad.scl_drive = 1'b0;
		pad.scl_value = 1'b1;

		case (phase)
			i2c_bus_pkg::idle: begin
				if (pending && !rx_busy)
					next_phase = i2c_bus_pkg::start;
			end

			i2c_bus_pkg::start: begin
				// SDA high for one phase, then low for the start condition
				pad.sda_drive = 1'b1;
				pad.scl_drive = 1'b1;
				bit_reload = 1'b1;
				if (count > phase_last) begin
					if (head_is_mark) begin
						next_phase = i2c_bus_pkg::stop1;
					end else begin
						pad.sda_value = 1'b0;
						if (count == start_last)
							next_phase = i2c_bus_pkg::bit_low;
					end
				end
			end

			i2c_bus_pkg::bit_low: begin
				pad.sda_drive = 1'b1;
				pad.scl_drive = 1'b1;
				pad.sda_value = q.entry.data[bit_idx];
				pad.scl_value = 1'b0;
				if (phase_done)
					next_phase = i2c_bus_pkg::bit_high;
			end

			i2c_bus_pkg::bit_high: begin
				pad.sda_drive = 1'b1;
				pad.scl_drive = 1'b1;
				pad.sda_value = q.entry.data[bit_idx];
				if (phase_done) begin
					bit_step = 1'b1;
					if (bit_idx != 3'd0)
						next_phase = i2c_bus_pkg::bit_low;
					else
						next_phase = i2c_bus_pkg::ack_low;
				end
			end

			i2c_bus_pkg::ack_low: begin
				// SDA is left to the slave for the whole ack slot
				pad.scl_drive = 1'b1;
				pad.scl_value = 1'b0;
				if (phase_done) begin
					q.pop = 1'b1;
					next_phase = i2c_bus_pkg::ack_high;
				end
			end

			i2c_bus_pkg::ack_high: begin
				pad.scl_drive = 1'b1;
				bit_reload = 1'b1;
				if (phase_done) begin
					if (head_is_mark)
						next_phase = i2c_bus_pkg::stop0;
					else
						next_phase = i2c_bus_pkg::bit_low;
				end
			end

			i2c_bus_pkg::stop0: begin
				pad.sda_drive = 1'b1;
				pad.scl_drive = 1'b1;
				pad.sda_value = 1'b0;
				pad.scl_value = 1'b0;
				if (phase_done)
					next_phase = i2c_bus_pkg::stop1;
			end

			i2c_bus_pkg::stop1: begin
				pad.sda_drive = 1'b1;
				pad.scl_drive = 1'b1;
				pad.sda_value = 1'b0;
				if (phase_done)
					next_phase = i2c_bus_pkg::stop2;
			end

			i2c_bus_pkg::stop2: begin
				// SDA rises with SCL high, then the frame mark is retired
				pad.sda_drive = 1'b1;
				pad.scl_drive = 1'b1;
				if (phase_done) begin
					q.pop = q.valid && q.entry.frame_end;
					next_phase = i2c_bus_pkg::idle;
				end
			end

			default: next_phase = i2c_bus_pkg::idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			phase <= i2c_bus_pkg::idle;
			count <= '0;
			bit_idx <= 3'd7;
			pending <= 1'b0;
		end else begin
			phase <= next_phase;
			pending <= frame_req || (pending && !frame_begin);
			if (next_phase != phase)
				count <= '0;
			else
				count <= count + 8'd1;
			if (bit_reload)
				bit_idx <= 3'd7;
			else if (bit_step)
				bit_idx <= bit_idx - 3'd1;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/tx_char_fifo.sv ====
`default_nettype none

module tx_char_fifo (
	input logic clk,
	input logic reset,
	input i2c_frame_pkg::queue_entry_t push_entry,
	input logic push,
	tx_queue_if.producer q
);
	localparam int depth = 2 ** i2c_frame_pkg::fifo_depth_log2;

	i2c_frame_pkg::queue_entry_t mem [depth];
	logic [i2c_frame_pkg::fifo_depth_log2-1:0] rd_ptr;
	logic [i2c_frame_pkg::fifo_depth_log2-1:0] wr_ptr;
	logic [i2c_frame_pkg::fifo_depth_log2:0] count;
	logic do_pop;

	// Pops against an empty queue are ignored
	assign do_pop = q.pop && q.valid;

	// The head is visible without a read cycle
	assign q.entry = mem[rd_ptr];
	assign q.valid = (count != '0);
	assign q.empty_frame_hint = q.valid && q.entry.frame_end;

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= push_entry;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (push && !do_pop)
				count <= count + 1'b1;
			else if (!push && do_pop)
				count <= count - 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/i2c_stage_if.sv ====
`default_nettype none

// Head of the transmit queue as seen by the sequencer
interface tx_queue_if;
	i2c_frame_pkg::queue_entry_t entry;
	logic valid;
	logic pop;
	// Set when the head is a frame mark
	logic empty_frame_hint;

	modport producer (
		output entry,
		output valid,
		output empty_frame_hint,
		input  pop
	);

	modport consumer (
		input  entry,
		input  valid,
		input  empty_frame_hint,
		output pop
	);
endinterface

// Per-phase drive requests from the sequencer to the pad stage
interface pad_ctrl_if;
	logic sda_drive;
	logic sda_value;
	logic scl_drive;
	logic scl_value;
	logic [7:0] phase_count;

	modport sequencer (
		output sda_drive,
		output sda_value,
		output scl_drive,
		output scl_value,
		output phase_count
	);

	modport pad (
		input sda_drive,
		input sda_value,
		input scl_drive,
		input scl_value,
		input phase_count
	);
endinterface

`default_nettype wire

// ==== hdl/i2c_frame_pkg.sv ====
`default_nettype none

package i2c_frame_pkg;

	// One queue slot holds either a char or a frame boundary mark
	typedef struct packed {
		logic       frame_end;
		logic [7:0] data;
	} queue_entry_t;

	// A received byte is payload for the user, but the first byte of a
	// frame is also looked up in the address bitmap
	typedef union packed {
		logic [7:0] data;
		struct packed {
			logic [3:0] word;
			logic [2:0] bit_idx;
			logic       rw;
		} addr;
	} rx_byte_u;

	// The bitmap covers all 128 seven-bit addresses, eight per word
	localparam int addr_table_words = 16;

	localparam int fifo_depth_log2 = 4;

endpackage

`default_nettype wire

// ==== hdl/i2c_bus_pkg.sv ====
`default_nettype none

package i2c_bus_pkg;

	// Sequencer phases, in the order a normal frame walks through them
	typedef enum logic [3:0] {
		idle,
		start,
		bit_low,
		bit_high,
		ack_low,
		ack_high,
		stop0,
		stop1,
		stop2
	} bus_phase_t;

	// Controls for one discrete pad; hiz set means the output buffer is off
	typedef struct packed {
		logic pd;
		logic pu;
		logic hiz;
	} pad_ctrl_t;

	// Clocks per bus phase, minus one
	localparam int default_phase_cycles = 99;

	// Clocks of active pull-up after SDA is let go
	localparam int default_release_cycles = 24;

endpackage

`default_nettype wire
